// File: verilog.f
+incdir+include
hdl/ofdm_demod_pkg.sv
hdl/cp_remover.sv
hdl/meta_fifo.sv
hdl/dft_engine.sv
hdl/cp_phase_rotator.sv
hdl/ofdm_demod_top.sv
bench/ofdm_demod_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the regression with the half-prefix advance on and off
cd "$(dirname "$0")" || exit 1

for adv in 1 0; do
    verilator --binary -Wno-fatal -f verilog.f --top-module ofdm_demod_tb \
        -GHALF_CP_ADVANCE=$adv -Mdir obj_dir_adv$adv \
        && ./obj_dir_adv$adv/Vofdm_demod_tb \
        || exit 1
done
exit 0

// File: include/ofdm_demod_ref.svh
`ifndef OFDM_DEMOD_REF_SVH
`define OFDM_DEMOD_REF_SVH

// window advance in samples is half of CP2 when enabled
function automatic int window_advance(input int nfft, input int half_cp_advance);
    return (half_cp_advance != 0) ? (18 * (1 << nfft) / 256) / 2 : 0;
endfunction

// exact integer DFT bin k of one window shifted right and truncated to 16-bit parts
function automatic ofdm_demod_pkg::sample_t dft_bin(
    input ofdm_demod_pkg::sample_t win[],
    input int                      k,
    input int                      nfft
);
    int     fft_len;
    int     idx;
    longint xr;
    longint xi;
    longint acc_re;
    longint acc_im;
    longint shr_re;
    longint shr_im;

    fft_len = 1 << nfft;
    acc_re  = 0;
    acc_im  = 0;
    for (int n = 0; n < fft_len; n++) begin
        idx    = (k * n) % fft_len;
        xr     = $signed(win[n][15:0]);
        xi     = $signed(win[n][31:16]);
        acc_re += xr * ofdm_demod_pkg::twiddle_re(idx, fft_len)
                - xi * ofdm_demod_pkg::twiddle_im(idx, fft_len);
        acc_im += xr * ofdm_demod_pkg::twiddle_im(idx, fft_len)
                + xi * ofdm_demod_pkg::twiddle_re(idx, fft_len);
    end
    shr_re = acc_re >>> (ofdm_demod_pkg::TW_FRAC + nfft);
    shr_im = acc_im >>> (ofdm_demod_pkg::TW_FRAC + nfft);
    return {shr_im[15:0], shr_re[15:0]};
endfunction

// clamp one component to the signed 16-bit range
function automatic ofdm_demod_pkg::comp_t saturate_part(input longint v);
    if (v > 32767) begin
        return 16'sh7fff;
    end
    if (v < -32768) begin
        return 16'sh8000;
    end
    return v[15:0];
endfunction

// rotates bin k back to the prefix-centred window and saturates
function automatic ofdm_demod_pkg::sample_t rotate_bin(
    input ofdm_demod_pkg::sample_t bin,
    input int                      k,
    input int                      nfft,
    input int                      adv
);
    longint br;
    longint bi;
    longint cr;
    longint ci;

    br = $signed(bin[15:0]);
    bi = $signed(bin[31:16]);
    cr = ofdm_demod_pkg::rot_re(k, 1 << nfft, adv);
    ci = ofdm_demod_pkg::rot_im(k, 1 << nfft, adv);
    return {saturate_part((br * ci + bi * cr) >>> ofdm_demod_pkg::TW_FRAC),
            saturate_part((br * cr - bi * ci) >>> ofdm_demod_pkg::TW_FRAC)};
endfunction

function automatic ofdm_demod_pkg::meta_t pack_meta(
    input ofdm_demod_pkg::sfn_t      sfn,
    input ofdm_demod_pkg::subframe_t sf,
    input ofdm_demod_pkg::symbol_t   sym
);
    return {sfn, sf, sym};
endfunction

// broadcast flag only on symbol 3 of subframe 0
function automatic ofdm_demod_pkg::user_out_t user_field(input ofdm_demod_pkg::meta_t m);
    return {m, (m[3:0] == ofdm_demod_pkg::BCH_SYMBOL) && (m[8:4] == '0)};
endfunction

`endif

// File: bench/ofdm_demod_tb.sv
`timescale 1ns/1ps

module ofdm_demod_tb
    import ofdm_demod_pkg::*;
#(
    parameter int NFFT            = 6,
    parameter int HALF_CP_ADVANCE = 1
);

    `include "ofdm_demod_ref.svh"

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int CP2     = 18 * FFT_LEN / 256;
    localparam int CP1     = 20 * FFT_LEN / 256;
    localparam int NSYM    = 8;
    // input slot per symbol at the DFT rate limit so the last bins overlap the next prefix
    localparam int SLOT    = FFT_LEN * FFT_LEN + FFT_LEN;
    // prefix sample that carries the late ssb strobe
    localparam int SSB_POS = 2;
    localparam int WATCHDOG_CYCLES = 16 + (NSYM + 1) * (FFT_LEN * FFT_LEN + 4 * FFT_LEN);

    logic      clk_i;
    logic      reset_ni;
    sample_t   s_data_i;
    user_in_t  s_user_i;
    logic      s_valid_i;
    logic      s_last_i;
    logic      ssb_start_i;
    sample_t   m_data_o;
    user_out_t m_user_o;
    logic      m_last_o;
    logic      m_valid_o;

    logic [31:0] rng;
    int          beats;
    sample_t     exp_data_q[$];
    user_out_t   exp_user_q[$];
    logic        exp_last_q[$];

    ofdm_demod_top #(
        .NFFT            (NFFT),
        .HALF_CP_ADVANCE (HALF_CP_ADVANCE)
    ) uut (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .s_data_i    (s_data_i),
        .s_user_i    (s_user_i),
        .s_valid_i   (s_valid_i),
        .s_last_i    (s_last_i),
        .ssb_start_i (ssb_start_i),
        .m_data_o    (m_data_o),
        .m_user_o    (m_user_o),
        .m_last_o    (m_last_o),
        .m_valid_o   (m_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // 12-bit signed parts sign extended into each half
    function sample_t random_sample();
        rng = next_random(rng);
        return {{4{rng[23]}}, rng[23:12], {4{rng[11]}}, rng[11:0]};
    endfunction

    // symbol 3 gets a late prefix strobe, symbol 5 an early tail strobe
    function automatic int strobe_kind(input int i);
        return (i == 3) ? 1 : ((i == 5) ? 2 : 0);
    endfunction

    function automatic int prefix_len(input int i);
        if (i == 3 || i == 5 || i == 6) begin
            return CP1;
        end
        return (i % 2 == 1) ? CP1 : CP2;
    endfunction

    function automatic bit has_tail(input int i);
        return (i == 3) || (i == 5) || (i % 3 == 1);
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_user(input string name, input user_out_t got, input user_out_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // ext holds two samples of the previous tail ahead of this period
    task automatic queue_expected(input sample_t ext[], input int offset, input meta_t m);
        sample_t win[];
        sample_t bin;

        win = new[FFT_LEN];
        for (int n = 0; n < FFT_LEN; n++) begin
            win[n] = ext[2 + offset + n];
        end
        for (int k = 0; k < FFT_LEN; k++) begin
            bin = dft_bin(win, k, NFFT);
            exp_data_q.push_back(rotate_bin(bin, k, NFFT, window_advance(NFFT, HALF_CP_ADVANCE)));
            exp_user_q.push_back(user_field(m));
            exp_last_q.push_back(k == FFT_LEN - 1);
        end
    endtask

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk_i) begin
        if (reset_ni === 1'b1) begin
            if (m_valid_o === 1'b1) begin
                if (exp_data_q.size() == 0) begin
                    stop_with_failure("an output beat arrived that no input symbol explains");
                end else begin
                    check_sample("m_data_o", m_data_o, exp_data_q.pop_front());
                    check_user("m_user_o", m_user_o, exp_user_q.pop_front());
                    check_last("m_last_o", m_last_o, exp_last_q.pop_front());
                    beats++;
                end
            end else if (m_valid_o !== 1'b0 || m_last_o !== 1'b0) begin
                stop_with_failure("output strobes were not low between beats");
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        stop_with_failure("timeout, not all output bins arrived in time");
    end

    initial begin
        sample_t ext[];
        sample_t prev_t0;
        sample_t prev_t1;
        meta_t   m;
        int      prev_kind;
        int      kind;
        int      cp;
        int      plen;
        int      offset;
        int      adv;

        rng         = 32'h7d46;
        beats       = 0;
        reset_ni    = 1'b0;
        s_data_i    = '0;
        s_user_i    = '0;
        s_valid_i   = 1'b0;
        s_last_i    = 1'b0;
        ssb_start_i = 1'b0;
        prev_t0     = '0;
        prev_t1     = '0;
        prev_kind   = 0;
        adv         = window_advance(NFFT, HALF_CP_ADVANCE);
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        reset_ni = 1'b1;
        repeat (4) @(negedge clk_i);

        for (int i = 0; i < NSYM; i++) begin
            kind = strobe_kind(i);
            cp   = prefix_len(i);
            plen = cp + FFT_LEN + (has_tail(i) ? 2 : 0);
            m    = pack_meta(sfn_t'(517), subframe_t'(i / 4), symbol_t'(i % 4));
            ext  = new[plen + 2];
            ext[0] = prev_t0;
            ext[1] = prev_t1;
            for (int j = 0; j < plen; j++) begin
                ext[j + 2] = random_sample();
            end
            // window start relative to the first prefix sample
            if (prev_kind == 2) begin
                offset = cp - adv - 2;
            end else if (kind == 1) begin
                offset = SSB_POS + cp - adv;
            end else begin
                offset = cp - adv;
            end
            queue_expected(ext, offset, m);

            for (int j = 0; j < plen; j++) begin
                @(negedge clk_i);
                s_valid_i   = 1'b1;
                s_data_i    = ext[j + 2];
                s_user_i    = {m, cp_len_t'(cp)};
                s_last_i    = (j == plen - 1);
                ssb_start_i = (kind == 1 && j == SSB_POS) || (kind == 2 && j == cp + FFT_LEN);
            end
            @(negedge clk_i);
            s_valid_i   = 1'b0;
            s_last_i    = 1'b0;
            ssb_start_i = 1'b0;
            prev_t0     = ext[plen];
            prev_t1     = ext[plen + 1];
            prev_kind   = kind;
            repeat (SLOT - plen - 1) @(negedge clk_i);
        end

        wait (beats == NSYM * FFT_LEN);
        // any extra beat in this stretch is caught by the checker
        repeat (4 * FFT_LEN) @(negedge clk_i);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: hdl/ofdm_demod_top.sv
`timescale 1ns/1ps

module ofdm_demod_top
    import ofdm_demod_pkg::*;
#(
    parameter int NFFT            = 6,
    parameter int HALF_CP_ADVANCE = 1
) (
    input  logic      clk_i,
    input  logic      reset_ni,
    input  sample_t   s_data_i,
    input  user_in_t  s_user_i,
    input  logic      s_valid_i,
    input  logic      s_last_i,
    input  logic      ssb_start_i,
    output sample_t   m_data_o,
    output user_out_t m_user_o,
    output logic      m_last_o,
    output logic      m_valid_o
);

    sample_t         win_data;
    logic            win_valid;
    logic            meta_push;
    meta_t           meta_in;
    meta_t           meta_head;
    sample_t         bin_data;
    logic            bin_valid;
    logic [NFFT-1:0] bin_index;
    logic            sym_done;

    cp_remover #(
        .NFFT            (NFFT),
        .HALF_CP_ADVANCE (HALF_CP_ADVANCE)
    ) u_cp_remover (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .s_data_i    (s_data_i),
        .s_user_i    (s_user_i),
        .s_valid_i   (s_valid_i),
        .s_last_i    (s_last_i),
        .ssb_start_i (ssb_start_i),
        .win_data_o  (win_data),
        .win_valid_o (win_valid),
        .meta_push_o (meta_push),
        .meta_o      (meta_in)
    );

    // frame metadata bypasses the DFT
    meta_fifo u_meta_fifo (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .push_i   (meta_push),
        .data_i   (meta_in),
        .pop_i    (sym_done),
        .data_o   (meta_head),
        .empty_o  ()
    );

    dft_engine #(
        .NFFT (NFFT)
    ) u_dft_engine (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .win_data_i  (win_data),
        .win_valid_i (win_valid),
        .bin_data_o  (bin_data),
        .bin_valid_o (bin_valid),
        .bin_index_o (bin_index),
        .sym_done_o  (sym_done)
    );

    cp_phase_rotator #(
        .NFFT            (NFFT),
        .HALF_CP_ADVANCE (HALF_CP_ADVANCE)
    ) u_cp_phase_rotator (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .bin_data_i  (bin_data),
        .bin_valid_i (bin_valid),
        .bin_index_i (bin_index),
        .meta_i      (meta_head),
        .m_data_o    (m_data_o),
        .m_user_o    (m_user_o),
        .m_last_o    (m_last_o),
        .m_valid_o   (m_valid_o)
    );

endmodule

// File: hdl/cp_phase_rotator.sv
`timescale 1ns/1ps

module cp_phase_rotator
    import ofdm_demod_pkg::*;
#(
    parameter int NFFT            = 6,
    parameter int HALF_CP_ADVANCE = 1
) (
    input  logic            clk_i,
    input  logic            reset_ni,
    input  sample_t         bin_data_i,
    input  logic            bin_valid_i,
    input  logic [NFFT-1:0] bin_index_i,
    input  meta_t           meta_i,
    output sample_t         m_data_o,
    output user_out_t       m_user_o,
    output logic            m_last_o,
    output logic            m_valid_o
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int CP2     = 18 * FFT_LEN / 256;
    // with no advance the coefficients are exactly one
    localparam int ADV     = (HALF_CP_ADVANCE != 0) ? CP2 / 2 : 0;
    localparam int PROD_W  = 2 * $bits(comp_t) + 1;
    localparam logic [NFFT-1:0] LAST_IDX = NFFT'(FFT_LEN - 1);

    comp_t rot_re_rom [FFT_LEN];
    comp_t rot_im_rom [FFT_LEN];

    comp_t b_re;
    comp_t b_im;
    comp_t c_re;
    comp_t c_im;

    logic signed [PROD_W-1:0] prod_re;
    logic signed [PROD_W-1:0] prod_im;
    logic                     valid_q;
    logic                     last_q;
    meta_t                    meta_q;
    subframe_t                meta_sf;
    symbol_t                  meta_sym;

    for (genvar i = 0; i < FFT_LEN; i++) begin : g_coeff
        assign rot_re_rom[i] = rot_re(i, FFT_LEN, ADV);
        assign rot_im_rom[i] = rot_im(i, FFT_LEN, ADV);
    end

    assign b_re = bin_data_i[15:0];
    assign b_im = bin_data_i[31:16];
    assign c_re = rot_re_rom[bin_index_i];
    assign c_im = rot_im_rom[bin_index_i];

    assign meta_sym = meta_q[$bits(symbol_t)-1:0];
    assign meta_sf  = meta_q[$bits(symbol_t) +: $bits(subframe_t)];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q   <= 1'b0;
            last_q    <= 1'b0;
            m_valid_o <= 1'b0;
            m_last_o  <= 1'b0;
        end else begin
            valid_q   <= bin_valid_i;
            last_q    <= bin_valid_i && (bin_index_i == LAST_IDX);
            m_valid_o <= valid_q;
            m_last_o  <= last_q;
        end
    end

    // meta is captured with the bin, the FIFO head moves on after the last one
    always_ff @(posedge clk_i) begin
        if (bin_valid_i) begin
            prod_re <= b_re * c_re - b_im * c_im;
            prod_im <= b_re * c_im + b_im * c_re;
            meta_q  <= meta_i;
        end
        if (valid_q) begin
            m_data_o <= {sat_comp(prod_im >>> TW_FRAC), sat_comp(prod_re >>> TW_FRAC)};
            m_user_o <= {meta_q, (meta_sym == BCH_SYMBOL) && (meta_sf == '0)};
        end
    end

endmodule

// File: hdl/dft_engine.sv
`timescale 1ns/1ps

module dft_engine
    import ofdm_demod_pkg::*;
#(
    parameter int NFFT = 6
) (
    input  logic            clk_i,
    input  logic            reset_ni,
    input  sample_t         win_data_i,
    input  logic            win_valid_i,
    output sample_t         bin_data_o,
    output logic            bin_valid_o,
    output logic [NFFT-1:0] bin_index_o,
    output logic            sym_done_o
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int ACC_W   = 2 * $bits(comp_t) + 1 + NFFT;
    localparam int SHIFT   = TW_FRAC + NFFT;
    localparam logic [NFFT-1:0] LAST_IDX = NFFT'(FFT_LEN - 1);

    sample_t sym_buf [2][FFT_LEN];
    comp_t   tw_re [FFT_LEN];
    comp_t   tw_im [FFT_LEN];

    logic            wr_sel;
    logic [NFFT-1:0] wr_cnt;
    logic [1:0]      buf_full;
    logic            rd_sel;
    logic            busy;
    logic [NFFT-1:0] k_cnt;
    logic [NFFT-1:0] n_cnt;
    logic [NFFT-1:0] tw_idx;
    logic            bin_end;

    sample_t x;
    comp_t   x_re;
    comp_t   x_im;
    comp_t   w_re;
    comp_t   w_im;

    logic signed [ACC_W-1:0] acc_re;
    logic signed [ACC_W-1:0] acc_im;
    logic signed [ACC_W-1:0] sum_re;
    logic signed [ACC_W-1:0] sum_im;
    logic signed [ACC_W-1:0] bin_re;
    logic signed [ACC_W-1:0] bin_im;

    for (genvar i = 0; i < FFT_LEN; i++) begin : g_twiddle
        assign tw_re[i] = twiddle_re(i, FFT_LEN);
        assign tw_im[i] = twiddle_im(i, FFT_LEN);
    end

    // k*n wraps modulo FFT_LEN in NFFT bits
    assign tw_idx  = k_cnt * n_cnt;
    assign bin_end = busy && (n_cnt == LAST_IDX);

    assign x    = sym_buf[rd_sel][n_cnt];
    assign x_re = x[15:0];
    assign x_im = x[31:16];
    assign w_re = tw_re[tw_idx];
    assign w_im = tw_im[tw_idx];

    // full-width complex multiply-accumulate
    assign sum_re = acc_re + x_re * w_re - x_im * w_im;
    assign sum_im = acc_im + x_re * w_im + x_im * w_re;
    assign bin_re = sum_re >>> SHIFT;
    assign bin_im = sum_im >>> SHIFT;

    always_ff @(posedge clk_i) begin
        if (win_valid_i) begin
            sym_buf[wr_sel][wr_cnt] <= win_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_sel      <= 1'b0;
            wr_cnt      <= '0;
            buf_full    <= '0;
            rd_sel      <= 1'b0;
            busy        <= 1'b0;
            k_cnt       <= '0;
            n_cnt       <= '0;
            bin_valid_o <= 1'b0;
            sym_done_o  <= 1'b0;
        end else begin
            bin_valid_o <= bin_end;
            sym_done_o  <= bin_end && (k_cnt == LAST_IDX);
            if (!busy) begin
                if (buf_full[rd_sel]) begin
                    busy  <= 1'b1;
                    k_cnt <= '0;
                    n_cnt <= '0;
                end
            end else begin
                n_cnt <= n_cnt + 1'b1;
                if (n_cnt == LAST_IDX) begin
                    k_cnt <= k_cnt + 1'b1;
                    if (k_cnt == LAST_IDX) begin
                        // symbol done, release the buffer to the write side
                        busy             <= 1'b0;
                        buf_full[rd_sel] <= 1'b0;
                        rd_sel           <= ~rd_sel;
                    end
                end
            end
            if (win_valid_i) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt == LAST_IDX) begin
                    buf_full[wr_sel] <= 1'b1;
                    wr_sel           <= ~wr_sel;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        acc_re <= (!busy || bin_end) ? '0 : sum_re;
        acc_im <= (!busy || bin_end) ? '0 : sum_im;
        if (bin_end) begin
            bin_data_o  <= {bin_im[15:0], bin_re[15:0]};
            bin_index_o <= k_cnt;
        end
    end

endmodule

// File: hdl/meta_fifo.sv
`timescale 1ns/1ps

module meta_fifo
    import ofdm_demod_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_ni,
    input  logic  push_i,
    input  meta_t data_i,
    input  logic  pop_i,
    output meta_t data_o,
    output logic  empty_o
);

    localparam int DEPTH = 4;
    localparam int AW    = $clog2(DEPTH);

    meta_t       mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i && (count != (AW + 1)'(DEPTH));
    assign do_pop  = pop_i && (count != '0);

    // head is visible without a read request
    assign data_o  = mem[rd_ptr];
    assign empty_o = (count == '0);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW + 1)'(do_push) - (AW + 1)'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

// File: hdl/cp_remover.sv
`timescale 1ns/1ps

module cp_remover
    import ofdm_demod_pkg::*;
#(
    parameter int NFFT            = 6,
    parameter int HALF_CP_ADVANCE = 1
) (
    input  logic     clk_i,
    input  logic     reset_ni,
    input  sample_t  s_data_i,
    input  user_in_t s_user_i,
    input  logic     s_valid_i,
    input  logic     s_last_i,
    input  logic     ssb_start_i,
    output sample_t  win_data_o,
    output logic     win_valid_o,
    output logic     meta_push_o,
    output meta_t    meta_o
);

    localparam int FFT_LEN = 2 ** NFFT;
    localparam int CP2     = 18 * FFT_LEN / 256;
    localparam logic [NFFT-1:0] LAST_IDX = NFFT'(FFT_LEN - 1);
    localparam logic [NFFT-1:0] PUSH_IDX = NFFT'(FFT_LEN - 2);

    in_state_e       state;
    cp_len_t         cur_cp_len;
    cp_len_t         cp_cnt;
    cp_len_t         start_cnt;
    logic [NFFT-1:0] in_cnt;
    logic            take;

    // prefix count starts past the part of the prefix that the window keeps
    assign start_cnt = (HALF_CP_ADVANCE != 0) ? (cur_cp_len >> 1) : '0;
    assign take      = s_valid_i && (state == TAKE_SYMBOL);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state       <= SKIP_PREFIX;
            cur_cp_len  <= cp_len_t'(CP2);
            cp_cnt      <= (HALF_CP_ADVANCE != 0) ? cp_len_t'(CP2 / 2) : '0;
            in_cnt      <= '0;
            win_valid_o <= 1'b0;
            meta_push_o <= 1'b0;
        end else begin
            win_valid_o <= take;
            meta_push_o <= take && (in_cnt == PUSH_IDX);
            // prefix length of the coming symbol rides on every sample
            if (s_valid_i) begin
                cur_cp_len <= s_user_i[$bits(cp_len_t)-1:0];
            end
            case (state)
                SKIP_PREFIX: begin
                    in_cnt <= '0;
                    if (ssb_start_i) begin
                        // late strobe, restart the prefix and move the window back
                        cp_cnt <= start_cnt + cp_len_t'(s_valid_i);
                    end else if (s_valid_i) begin
                        if (cp_cnt >= cur_cp_len - 5'd1) begin
                            state  <= TAKE_SYMBOL;
                            cp_cnt <= '0;
                        end else begin
                            cp_cnt <= cp_cnt + 5'd1;
                        end
                    end
                end
                TAKE_SYMBOL: begin
                    if (s_valid_i) begin
                        if (in_cnt != LAST_IDX) begin
                            in_cnt <= in_cnt + 1'b1;
                        end else begin
                            cp_cnt <= start_cnt;
                            state  <= s_last_i ? SKIP_PREFIX : SKIP_END;
                        end
                    end
                end
                SKIP_END: begin
                    if (s_valid_i && s_last_i) begin
                        state <= SKIP_PREFIX;
                    end else if (ssb_start_i) begin
                        // early strobe, the tail is cut short
                        state  <= SKIP_PREFIX;
                        cp_cnt <= cp_cnt + cp_len_t'(s_valid_i);
                    end
                end
                default: state <= SKIP_PREFIX;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_valid_i) begin
            win_data_o <= s_data_i;
        end
        if (take && (in_cnt == PUSH_IDX)) begin
            meta_o <= s_user_i[$bits(user_in_t)-1 -: $bits(meta_t)];
        end
    end

endmodule

// File: hdl/ofdm_demod_pkg.sv
package ofdm_demod_pkg;

    typedef logic [31:0]        sample_t;
    typedef logic signed [15:0] comp_t;
    typedef logic [9:0]         sfn_t;
    typedef logic [4:0]         subframe_t;
    typedef logic [3:0]         symbol_t;
    typedef logic [4:0]         cp_len_t;
    typedef logic [18:0]        meta_t;
    typedef logic [23:0]        user_in_t;
    typedef logic [19:0]        user_out_t;

    // fraction bits of twiddles and rotation coefficients
    localparam int TW_FRAC = 14;
    // broadcast channel sits in this symbol of subframe 0
    localparam symbol_t BCH_SYMBOL = 4'd3;

    localparam longint COMP_MAX = 2 ** ($bits(comp_t) - 1) - 1;
    localparam longint COMP_MIN = -(2 ** ($bits(comp_t) - 1));

    typedef enum logic [1:0] {
        SKIP_PREFIX,
        TAKE_SYMBOL,
        SKIP_END
    } in_state_e;

    // int'() of a real rounds to nearest
    function automatic comp_t twiddle_re(input int n, input int fft_len);
        return comp_t'(int'($cos(2.0 * 3.14159265358979 * n / fft_len) * 2.0 ** TW_FRAC));
    endfunction

    function automatic comp_t twiddle_im(input int n, input int fft_len);
        return comp_t'(int'(-$sin(2.0 * 3.14159265358979 * n / fft_len) * 2.0 ** TW_FRAC));
    endfunction

    // undoes the phase ramp of a window that starts adv samples early
    function automatic comp_t rot_re(input int k, input int fft_len, input int adv);
        return comp_t'(int'($cos(2.0 * 3.14159265358979 * k * adv / fft_len) * 2.0 ** TW_FRAC));
    endfunction

    function automatic comp_t rot_im(input int k, input int fft_len, input int adv);
        return comp_t'(int'($sin(2.0 * 3.14159265358979 * k * adv / fft_len) * 2.0 ** TW_FRAC));
    endfunction

    // clamp to the range of one component
    function automatic comp_t sat_comp(input longint v);
        if (v > COMP_MAX) begin
            return comp_t'(COMP_MAX);
        end
        if (v < COMP_MIN) begin
            return comp_t'(COMP_MIN);
        end
        return comp_t'(v);
    endfunction

endpackage
